// ==== logic/rv_isa_pkg.sv ====
// RV32 instruction-set definitions shared by decode, datapath and testbench
package rv_isa_pkg;

	localparam int unsigned XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [31:0]     instr_t;
	typedef logic [4:0]      reg_addr_t;

	// Major opcodes
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	// funct3, MUL also uses 000
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7
	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_SUB    = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

// ==== logic/pipe_pkg.sv ====
// Pipeline-internal definitions, imported by the core modules and the testbench
package pipe_pkg;

	// Operation carried from decode to execute
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_MUL
	} alu_op_e;

	// Multiply latency in register stages after execute
	localparam int unsigned MULT_STAGES_DEF = 5;

endpackage

// ==== logic/issue_if.sv ====
// Issue bundle from decode into execute, also watched by the hazard logic
`timescale 1ns/100ps

interface issue_if import rv_isa_pkg::*, pipe_pkg::*; (
	input logic clk_i
);

	logic      valid;
	alu_op_e   op;
	word_t     data_a;
	word_t     data_b;
	reg_addr_t rd;

	modport master (output valid, output op, output data_a, output data_b, output rd);

	modport execute (input clk_i, input valid, input op, input data_a, input data_b, input rd);

	// Hazard detection only needs to know what is in flight
	modport observe (input valid, input op, input rd);

endinterface

// ==== logic/decode_stage.sv ====
// Decodes instr_i into an ALU operation and loads the issue register for execute
`timescale 1ns/100ps

module decode_stage import rv_isa_pkg::*, pipe_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      instr_valid_i,
	input  instr_t    instr_i,
	input  logic      stall_i,
	output reg_addr_t rs1_o,
	output reg_addr_t rs2_o,
	output logic      is_alu_o,
	input  word_t     opnd_a_i,
	input  word_t     opnd_b_i,
	issue_if.master   issue
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t  rd;
	word_t      imm;
	alu_op_e    op_d;
	logic       supported;
	logic       use_imm;

	assign opcode = instr_i[6:0];
	assign rd     = instr_i[11:7];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign imm    = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

	always_comb begin
		op_d      = ALU_ADD;
		supported = 1'b0;
		use_imm   = 1'b0;
		case (opcode)
			OPC_OP_IMM: begin
				// Only ADDI is kept from the immediate group
				supported = (funct3 == F3_ADD_SUB);
				use_imm   = 1'b1;
			end
			OPC_OP: begin
				supported = 1'b1;
				case ({funct7, funct3})
					{F7_BASE, F3_ADD_SUB}:   op_d = ALU_ADD;
					{F7_SUB, F3_ADD_SUB}:    op_d = ALU_SUB;
					{F7_BASE, F3_AND}:       op_d = ALU_AND;
					{F7_BASE, F3_OR}:        op_d = ALU_OR;
					{F7_BASE, F3_XOR}:       op_d = ALU_XOR;
					{F7_MULDIV, F3_ADD_SUB}: op_d = ALU_MUL;
					default:                 supported = 1'b0;
				endcase
			end
			default: begin
				supported = 1'b0;
			end
		endcase
	end

	// Idle slots and the ADDI immediate field must not look like source registers
	assign rs1_o    = instr_valid_i ? instr_i[19:15] : '0;
	assign rs2_o    = (instr_valid_i && !use_imm) ? instr_i[24:20] : '0;
	assign is_alu_o = instr_valid_i && supported && (op_d != ALU_MUL);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= instr_valid_i && !stall_i && supported && (rd != '0);
		end
	end

	always_ff @(posedge clk_i) begin
		issue.op     <= op_d;
		issue.rd     <= rd;
		issue.data_a <= opnd_a_i;
		issue.data_b <= use_imm ? imm : opnd_b_i;
	end

	// A stalled instruction is presented again unchanged in the next cycle
	a_hold_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(instr_valid_i && stall_i) |=> (instr_valid_i && $stable(instr_i)));

endmodule

// ==== logic/reg_file.sv ====
// Integer register file, two write-first read ports and one write port
`timescale 1ns/100ps

module reg_file import rv_isa_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  reg_addr_t raddr_a_i,
	input  reg_addr_t raddr_b_i,
	output word_t     rdata_a_o,
	output word_t     rdata_b_o,
	input  logic      we_i,
	input  reg_addr_t waddr_i,
	input  word_t     wdata_i
);

	localparam int unsigned NUM_REGS = 1 << $bits(reg_addr_t);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 is hardwired, a same-cycle write is seen by the reader
	assign rdata_a_o = (raddr_a_i == '0) ? '0 :
	                   (we_i && (waddr_i == raddr_a_i)) ? wdata_i : regs[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 :
	                   (we_i && (waddr_i == raddr_b_i)) ? wdata_i : regs[raddr_b_i];

endmodule

// ==== logic/bypass_ctrl.sv ====
// Operand forwarding and hazard stall for the instruction in decode
`timescale 1ns/100ps

module bypass_ctrl import rv_isa_pkg::*, pipe_pkg::*; #(
	parameter int unsigned MULT_STAGES = MULT_STAGES_DEF
) (
	input  reg_addr_t                   rs1_i,
	input  reg_addr_t                   rs2_i,
	input  logic                        is_alu_i,
	issue_if.observe                    issue,
	input  word_t                       alu_data_i,
	input  logic [MULT_STAGES-1:0]      mul_busy_i,
	input  reg_addr_t [MULT_STAGES-1:0] mul_rd_i,
	input  word_t                       mul_last_data_i,
	input  logic                        wb_valid_i,
	input  reg_addr_t                   wb_rd_i,
	input  word_t                       wb_data_i,
	input  word_t                       rf_a_i,
	input  word_t                       rf_b_i,
	output word_t                       opnd_a_o,
	output word_t                       opnd_b_o,
	output logic                        stall_o
);

	reg_addr_t [1:0] rs_src;
	word_t [1:0]     rf_data;
	word_t [1:0]     opnd;
	logic            issue_alu;
	logic            issue_mul;
	logic            mul_early;
	logic            hazard;

	assign rs_src    = {rs2_i, rs1_i};
	assign rf_data   = {rf_b_i, rf_a_i};
	assign issue_alu = issue.valid && (issue.op != ALU_MUL);
	assign issue_mul = issue.valid && (issue.op == ALU_MUL);
	assign mul_early = issue_mul || (|mul_busy_i[MULT_STAGES-2:0]);

	always_comb begin
		hazard = 1'b0;
		for (int k = 0; k < 2; k++) begin
			// Lowest priority first, later matches override
			opnd[k] = rf_data[k];
			if (wb_valid_i && (wb_rd_i == rs_src[k]))
				opnd[k] = wb_data_i;
			if (mul_busy_i[MULT_STAGES-1] && (mul_rd_i[MULT_STAGES-1] == rs_src[k]))
				opnd[k] = mul_last_data_i;
			if (issue_alu && (issue.rd == rs_src[k]))
				opnd[k] = alu_data_i;
			// Product not ready before the last stage
			if (rs_src[k] != '0) begin
				if (issue_mul && (issue.rd == rs_src[k]))
					hazard = 1'b1;
				for (int i = 0; i < MULT_STAGES - 1; i++) begin
					if (mul_busy_i[i] && (mul_rd_i[i] == rs_src[k]))
						hazard = 1'b1;
				end
			end
		end
	end

	assign opnd_a_o = opnd[0];
	assign opnd_b_o = opnd[1];

	// An ALU op issued now would reach writeback with or ahead of an older MUL
	assign stall_o = hazard || (is_alu_i && mul_early);

endmodule

// ==== logic/exe_stage.sv ====
// Single-cycle ALU and multiplier product computed from the issue register
`timescale 1ns/100ps

module exe_stage import rv_isa_pkg::*, pipe_pkg::*; (
	issue_if.execute issue,
	output logic      alu_valid_o,
	output reg_addr_t alu_rd_o,
	output word_t     alu_data_o,
	output logic      mul_valid_o,
	output reg_addr_t mul_rd_o,
	output word_t     mul_product_o
);

	always_comb begin
		case (issue.op)
			ALU_ADD: alu_data_o = issue.data_a + issue.data_b;
			ALU_SUB: alu_data_o = issue.data_a - issue.data_b;
			ALU_AND: alu_data_o = issue.data_a & issue.data_b;
			ALU_OR:  alu_data_o = issue.data_a | issue.data_b;
			ALU_XOR: alu_data_o = issue.data_a ^ issue.data_b;
			default: alu_data_o = '0;
		endcase
	end

	// Low half of the product only
	assign mul_product_o = issue.data_a * issue.data_b;

	assign alu_valid_o = issue.valid && (issue.op != ALU_MUL);
	assign alu_rd_o    = issue.rd;
	assign mul_valid_o = issue.valid && (issue.op == ALU_MUL);
	assign mul_rd_o    = issue.rd;

	// A valid issue never lands in the default ALU branch
	a_known_op: assert property (@(posedge issue.clk_i)
		issue.valid |-> (issue.op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_MUL}));

endmodule

// ==== logic/mult_pipe.sv ====
// Multiply delay line, carries products from execute to writeback
`timescale 1ns/100ps

module mult_pipe import rv_isa_pkg::*, pipe_pkg::*; #(
	parameter int unsigned MULT_STAGES = MULT_STAGES_DEF
) (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic                        mul_valid_i,
	input  reg_addr_t                   mul_rd_i,
	input  word_t                       mul_product_i,
	output logic [MULT_STAGES-1:0]      busy_o,
	output reg_addr_t [MULT_STAGES-1:0] rd_o,
	output logic                        last_valid_o,
	output reg_addr_t                   last_rd_o,
	output word_t                       last_data_o
);

	logic [MULT_STAGES-1:0]      vld_q;
	reg_addr_t [MULT_STAGES-1:0] rd_q;
	word_t [MULT_STAGES-1:0]     data_q;

	// Index 0 is the first stage after execute
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[MULT_STAGES-2:0], mul_valid_i};
		end
	end

	always_ff @(posedge clk_i) begin
		rd_q   <= {rd_q[MULT_STAGES-2:0], mul_rd_i};
		data_q <= {data_q[MULT_STAGES-2:0], mul_product_i};
	end

	assign busy_o       = vld_q;
	assign rd_o         = rd_q;
	assign last_valid_o = vld_q[MULT_STAGES-1];
	assign last_rd_o    = rd_q[MULT_STAGES-1];
	assign last_data_o  = data_q[MULT_STAGES-1];

endmodule

// ==== logic/writeback_stage.sv ====
// Writeback register, merges the ALU and multiply result paths
`timescale 1ns/100ps

module writeback_stage import rv_isa_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      alu_valid_i,
	input  reg_addr_t alu_rd_i,
	input  word_t     alu_data_i,
	input  logic      mul_valid_i,
	input  reg_addr_t mul_rd_i,
	input  word_t     mul_data_i,
	output logic      wb_valid_o,
	output reg_addr_t wb_rd_o,
	output word_t     wb_data_o
);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= alu_valid_i || mul_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		wb_rd_o   <= alu_valid_i ? alu_rd_i : mul_rd_i;
		wb_data_o <= alu_valid_i ? alu_data_i : mul_data_i;
	end

	// Decode stalls keep the two paths from arriving together
	a_no_collision: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(alu_valid_i && mul_valid_i));

endmodule

// ==== logic/vi_core.sv ====
// Integer core top level, instruction strobe in and writeback pulses out
`timescale 1ns/100ps

module vi_core import rv_isa_pkg::*, pipe_pkg::*; #(
	parameter int unsigned MULT_STAGES = MULT_STAGES_DEF
) (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      instr_valid_i,
	input  instr_t    instr_i,
	output logic      stall_o,
	output logic      wb_valid_o,
	output reg_addr_t wb_rd_o,
	output word_t     wb_data_o
);

	reg_addr_t                   rs1;
	reg_addr_t                   rs2;
	logic                        is_alu;
	word_t                       rf_a;
	word_t                       rf_b;
	word_t                       opnd_a;
	word_t                       opnd_b;
	logic                        alu_valid;
	reg_addr_t                   alu_rd;
	word_t                       alu_data;
	logic                        mul_valid;
	reg_addr_t                   mul_rd;
	word_t                       mul_product;
	logic [MULT_STAGES-1:0]      mul_busy;
	reg_addr_t [MULT_STAGES-1:0] mul_stage_rd;
	logic                        mul_last_valid;
	reg_addr_t                   mul_last_rd;
	word_t                       mul_last_data;

	issue_if issue (.clk_i(clk_i));

	decode_stage decode_stage (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.instr_valid_i	(instr_valid_i),
		.instr_i	(instr_i),
		.stall_i	(stall_o),
		.rs1_o		(rs1),
		.rs2_o		(rs2),
		.is_alu_o	(is_alu),
		.opnd_a_i	(opnd_a),
		.opnd_b_i	(opnd_b),
		.issue		(issue.master)
	);

	reg_file reg_file (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.raddr_a_i	(rs1),
		.raddr_b_i	(rs2),
		.rdata_a_o	(rf_a),
		.rdata_b_o	(rf_b),
		.we_i		(wb_valid_o),
		.waddr_i	(wb_rd_o),
		.wdata_i	(wb_data_o)
	);

	bypass_ctrl #(
		.MULT_STAGES	(MULT_STAGES)
	) bypass_ctrl (
		.rs1_i			(rs1),
		.rs2_i			(rs2),
		.is_alu_i		(is_alu),
		.issue			(issue.observe),
		.alu_data_i		(alu_data),
		.mul_busy_i		(mul_busy),
		.mul_rd_i		(mul_stage_rd),
		.mul_last_data_i	(mul_last_data),
		.wb_valid_i		(wb_valid_o),
		.wb_rd_i		(wb_rd_o),
		.wb_data_i		(wb_data_o),
		.rf_a_i			(rf_a),
		.rf_b_i			(rf_b),
		.opnd_a_o		(opnd_a),
		.opnd_b_o		(opnd_b),
		.stall_o		(stall_o)
	);

	exe_stage exe_stage (
		.issue		(issue.execute),
		.alu_valid_o	(alu_valid),
		.alu_rd_o	(alu_rd),
		.alu_data_o	(alu_data),
		.mul_valid_o	(mul_valid),
		.mul_rd_o	(mul_rd),
		.mul_product_o	(mul_product)
	);

	mult_pipe #(
		.MULT_STAGES	(MULT_STAGES)
	) mult_pipe (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.mul_valid_i	(mul_valid),
		.mul_rd_i	(mul_rd),
		.mul_product_i	(mul_product),
		.busy_o		(mul_busy),
		.rd_o		(mul_stage_rd),
		.last_valid_o	(mul_last_valid),
		.last_rd_o	(mul_last_rd),
		.last_data_o	(mul_last_data)
	);

	writeback_stage writeback_stage (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.alu_valid_i	(alu_valid),
		.alu_rd_i	(alu_rd),
		.alu_data_i	(alu_data),
		.mul_valid_i	(mul_last_valid),
		.mul_rd_i	(mul_last_rd),
		.mul_data_i	(mul_last_data),
		.wb_valid_o	(wb_valid_o),
		.wb_rd_o	(wb_rd_o),
		.wb_data_o	(wb_data_o)
	);

endmodule

// ==== bench/tb_clock.sv ====
// Testbench clock and reset source, 4 ns clock with reset held low for the first cycles
`timescale 1ns/100ps

module tb_clock #(
	parameter int unsigned RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1 rst_n_o = 1'b1;
	end

endmodule

// ==== bench/tb_vi_core.sv ====
// Randomized testbench for vi_core that compares every writeback with an ISA-level model
`timescale 1ns/100ps

module tb_vi_core import rv_isa_pkg::*, pipe_pkg::*; ();

	localparam int unsigned MULT_STAGES = MULT_STAGES_DEF;
	localparam int unsigned TIMEOUT     = 200;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	instr_t      instr;
	logic        stall;
	logic        wb_valid;
	reg_addr_t   wb_rd;
	word_t       wb_data;
	logic [31:0] rng_state = 32'h1529_5aaa;
	int unsigned cycle = 0;
	int unsigned wb_count = 0;
	int unsigned value_errors = 0;
	int unsigned other_errors = 0;
	word_t       model_regs [32];
	reg_addr_t   exp_rd_q [$];
	word_t       exp_data_q [$];
	int          exp_cycle_q [$];

	tb_clock clock_gen (.clk_o(clk), .rst_n_o(rst_n));

	vi_core #(
		.MULT_STAGES	(MULT_STAGES)
	) uut (
		.clk_i		(clk),
		.rst_n_i	(rst_n),
		.instr_valid_i	(instr_valid),
		.instr_i	(instr),
		.stall_o	(stall),
		.wb_valid_o	(wb_valid),
		.wb_rd_o	(wb_rd),
		.wb_data_o	(wb_data)
	);

	always @(posedge clk) cycle <= cycle + 1;

	function automatic int unsigned pick(input int unsigned n);
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state % n;
	endfunction

	function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic instr_t enc_addi(input logic [11:0] imm, input reg_addr_t rs1,
			input reg_addr_t rd);
		return {imm, rs1, F3_ADD_SUB, rd, OPC_OP_IMM};
	endfunction

	function automatic instr_t random_instr(input int unsigned nregs, input bit with_mul,
			input bit with_odd);
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		logic [11:0] imm;
		int unsigned sel;
		rd  = reg_addr_t'(pick(nregs));
		rs1 = reg_addr_t'(pick(nregs));
		rs2 = reg_addr_t'(pick(nregs));
		imm = 12'(pick(4096));
		sel = pick(20);
		if (with_mul && sel < 5)
			return enc_r(F7_MULDIV, rs2, rs1, F3_ADD_SUB, rd);
		// Encodings outside the supported set
		if (with_odd && sel == 5)
			return enc_r(F7_SUB, rs2, rs1, F3_XOR, rd);
		if (with_odd && sel == 6)
			return {imm, rs1, F3_XOR, rd, OPC_OP_IMM};
		if (with_odd && sel == 7)
			return {imm, rs1, F3_ADD_SUB, rd, 7'b0000011};
		case (pick(6))
			0:       return enc_r(F7_BASE, rs2, rs1, F3_ADD_SUB, rd);
			1:       return enc_r(F7_SUB, rs2, rs1, F3_ADD_SUB, rd);
			2:       return enc_r(F7_BASE, rs2, rs1, F3_AND, rd);
			3:       return enc_r(F7_BASE, rs2, rs1, F3_OR, rd);
			4:       return enc_r(F7_BASE, rs2, rs1, F3_XOR, rd);
			default: return enc_addi(imm, rs1, rd);
		endcase
	endfunction

	// Executes an accepted instruction and queues the writeback it should make
	task automatic model_accept(input instr_t in, input bit check_lat);
		reg_addr_t rd;
		word_t     a;
		word_t     b;
		word_t     imm;
		word_t     res;
		logic      ok;
		logic      is_mul;
		rd     = in[11:7];
		a      = model_regs[in[19:15]];
		b      = model_regs[in[24:20]];
		imm    = {{20{in[31]}}, in[31:20]};
		res    = '0;
		ok     = 1'b1;
		is_mul = 1'b0;
		if (in[6:0] == OPC_OP_IMM && in[14:12] == F3_ADD_SUB)
			res = a + imm;
		else if (in[6:0] == OPC_OP && in[14:12] == F3_ADD_SUB && in[31:25] == F7_BASE)
			res = a + b;
		else if (in[6:0] == OPC_OP && in[14:12] == F3_ADD_SUB && in[31:25] == F7_SUB)
			res = a - b;
		else if (in[6:0] == OPC_OP && in[14:12] == F3_AND && in[31:25] == F7_BASE)
			res = a & b;
		else if (in[6:0] == OPC_OP && in[14:12] == F3_OR && in[31:25] == F7_BASE)
			res = a | b;
		else if (in[6:0] == OPC_OP && in[14:12] == F3_XOR && in[31:25] == F7_BASE)
			res = a ^ b;
		else if (in[6:0] == OPC_OP && in[14:12] == F3_ADD_SUB && in[31:25] == F7_MULDIV) begin
			res    = a * b;
			is_mul = 1'b1;
		end else
			ok = 1'b0;
		if (ok && rd != '0) begin
			model_regs[rd] = res;
			exp_rd_q.push_back(rd);
			exp_data_q.push_back(res);
			// Retire edge counted from the decode cycle
			if (check_lat)
				exp_cycle_q.push_back(int'(cycle) + (is_mul ? int'(MULT_STAGES) + 2 : 2));
			else
				exp_cycle_q.push_back(-1);
		end
	endtask

	task automatic finish_run();
		$display("Writebacks %0d, value errors %0d, other errors %0d",
			wb_count, value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic check_writeback();
		reg_addr_t exp_rd;
		word_t     exp_data;
		int        exp_cycle;
		wb_count++;
		if (exp_rd_q.size() == 0) begin
			other_errors++;
			$display("%0t: unexpected writeback of %h to x%0d", $time, wb_data, wb_rd);
		end else begin
			exp_rd    = exp_rd_q.pop_front();
			exp_data  = exp_data_q.pop_front();
			exp_cycle = exp_cycle_q.pop_front();
			assert (wb_rd == exp_rd) else begin
				value_errors++;
				$display("[ERROR] %0t wb_rd_o expected %0d got %0d", $time, exp_rd, wb_rd);
			end
			assert (wb_data == exp_data) else begin
				value_errors++;
				$display("[ERROR] %0t wb_data_o expected %h got %h", $time, exp_data, wb_data);
			end
			assert (exp_cycle < 0 || int'(cycle) == exp_cycle) else begin
				value_errors++;
				$display("[ERROR] %0t wb_valid_o expected at cycle %0d got cycle %0d",
					$time, exp_cycle, cycle);
			end
		end
	endtask

	// Registered outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n && wb_valid)
			check_writeback();
	end

	// Presents one instruction and holds it until the core takes it
	task automatic send(input instr_t in, input bit check_lat, output int unsigned stalls);
		stalls      = 0;
		instr_valid = 1'b1;
		instr       = in;
		#2;
		while (stall && stalls < TIMEOUT) begin
			stalls++;
			@(posedge clk);
			#3;
		end
		if (stall) begin
			other_errors++;
			$display("%0t: instruction %h was never accepted", $time, in);
			finish_run();
		end else begin
			model_accept(in, check_lat);
			@(posedge clk);
			#1;
			instr_valid = 1'b0;
		end
	endtask

	task automatic idle(input int unsigned n);
		instr_valid = 1'b0;
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic drain();
		int unsigned n;
		n = 0;
		while (exp_rd_q.size() != 0 && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (exp_rd_q.size() != 0) begin
			other_errors++;
			$display("%0t: %0d expected writebacks never arrived", $time, exp_rd_q.size());
			finish_run();
		end
	endtask

	task automatic wait_reset();
		int unsigned n;
		n = 0;
		while (!rst_n && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!rst_n) begin
			other_errors++;
			$display("%0t: reset was never released", $time);
			finish_run();
		end else begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_quiet(input int unsigned n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#3;
			assert (!stall) else begin
				value_errors++;
				$display("[ERROR] %0t stall_o expected 0 got %b", $time, stall);
			end
			assert (!wb_valid) else begin
				value_errors++;
				$display("[ERROR] %0t wb_valid_o expected 0 got %b", $time, wb_valid);
			end
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		int unsigned stalls;
		instr_valid = 1'b0;
		instr       = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		wait_reset();
		check_quiet(20);

		// ALU and ADDI over the whole register file
		for (int i = 0; i < 300; i++) begin
			send(random_instr(32, 1'b0, 1'b0), 1'b0, stalls);
			if (pick(8) == 0)
				idle(1);
		end
		drain();

		// Isolated latencies with full-width register values
		send(enc_r(F7_MULDIV, 5'd9, 5'd8, F3_ADD_SUB, 5'd7), 1'b1, stalls);
		drain();
		send(enc_r(F7_SUB, 5'd12, 5'd11, F3_ADD_SUB, 5'd10), 1'b1, stalls);
		drain();

		// Independent ALU op right behind a MUL must wait for it
		send(enc_r(F7_MULDIV, 5'd15, 5'd14, F3_ADD_SUB, 5'd13), 1'b1, stalls);
		send(enc_r(F7_BASE, 5'd18, 5'd17, F3_XOR, 5'd16), 1'b0, stalls);
		assert (stalls > 0) else begin
			other_errors++;
			$display("%0t: ALU instruction behind a MUL was not stalled", $time);
		end
		drain();

		// x0 destination, unsupported encodings and x0 sources
		send(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd0), 1'b0, stalls);
		send({12'h0ff, 5'd3, F3_XOR, 5'd4, OPC_OP_IMM}, 1'b0, stalls);
		send({7'b0000000, 5'd2, 5'd1, 3'b001, 5'd4, OPC_OP}, 1'b0, stalls);
		send(enc_r(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd5), 1'b0, stalls);
		send(enc_addi(12'h9ab, 5'd0, 5'd6), 1'b0, stalls);
		send(enc_r(F7_MULDIV, 5'd0, 5'd6, F3_ADD_SUB, 5'd7), 1'b0, stalls);
		drain();
		idle(10);

		// Dense mix on few registers for forwarding and multiply hazards
		for (int i = 0; i < 400; i++)
			send(random_instr(5, 1'b1, 1'b1), 1'b0, stalls);
		drain();
		idle(10);
		finish_run();
	end

endmodule

// ==== files.f ====
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/issue_if.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/bypass_ctrl.sv
logic/exe_stage.sv
logic/mult_pipe.sv
logic/writeback_stage.sv
logic/vi_core.sv
bench/tb_clock.sv
bench/tb_vi_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        := tb_vi_core
RTL_TOP    := vi_core
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
